// File: source/conv_pkg.sv
package conv_pkg;

	// ****************************************
	// widths and limits of the 4-digit format

	localparam int TAG_W     = 4;
	localparam int OPERAND_W = 16;
	localparam int BIN_W     = 14;
	localparam int ITER_W    = 4;

	localparam logic [ITER_W-1:0]    CONV_ITER = 4'd14; // shift steps per conversion
	localparam logic [OPERAND_W-1:0] BCD_MAX   = 16'd9999;
	localparam logic [3:0]           DIGIT_MAX = 4'd9;

	// ****************************************
	// opcodes and engine states

	typedef enum logic [1:0] {
		OP_NONE    = 2'd0,
		OP_BCD2BIN = 2'd1,
		OP_BIN2BCD = 2'd2,
		OP_RSVD    = 2'd3
	} conv_op_e;

	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_OP   = 2'd1,
		ST_DONE = 2'd2
	} eng_state_e;

	// ****************************************
	// command and result words

	typedef struct packed {
		conv_op_e             op;
		logic [TAG_W-1:0]     tag;
		logic [OPERAND_W-1:0] operand; // digits msd first, or binary in low bits
	} conv_cmd_t;

	typedef struct packed {
		conv_op_e             op;
		logic [TAG_W-1:0]     tag;
		logic [OPERAND_W-1:0] value;
		logic                 err;     // operand could not be converted
	} conv_res_t;

endpackage

// File: source/bcd2bin.sv
`timescale 1ns/100ps

module bcd2bin
	(
		input  logic                iCLK,
		input  logic                iRESET,
		input  logic                start,
		input  conv_pkg::conv_cmd_t cmd,
		input  logic                grant,
		output logic                ready,
		output logic                req,
		output conv_pkg::conv_res_t res
	);

	import conv_pkg::*;

	eng_state_e        state_reg, state_next;
	logic [ITER_W-1:0] n_reg, n_next;
	logic [BIN_W-1:0]  bin_reg, bin_next;
	logic [3:0][3:0]   bcd_reg, bcd_next, bcd_tmp;
	conv_op_e          op_reg;
	logic [TAG_W-1:0]  tag_reg;
	logic              err_reg;
	logic              digit_bad;

	always_ff @(posedge iCLK, posedge iRESET)
		if (iRESET)
		begin
			state_reg <= ST_IDLE;
			n_reg     <= '0;
		end
		else
		begin
			state_reg <= state_next;
			n_reg     <= n_next;
		end

	always_ff @(posedge iCLK)
	begin
		bin_reg <= bin_next;
		bcd_reg <= bcd_next;
		if (start && state_reg == ST_IDLE)
		begin
			op_reg  <= cmd.op;
			tag_reg <= cmd.tag;
			err_reg <= digit_bad;
		end
	end

	always_comb
	begin
		digit_bad = 1'b0;
		for (int i = 0; i < 4; i++)
			if (cmd.operand[4*i +: 4] > DIGIT_MAX)
				digit_bad = 1'b1;
	end

	// shift all digits right by one, lsb of each digit drops into the next
	always_comb
	begin
		for (int i = 0; i < 3; i++)
			bcd_tmp[i] = {bcd_reg[i+1][0], bcd_reg[i][3:1]};
		bcd_tmp[3] = {1'b0, bcd_reg[3][3:1]};
	end

	always_comb
	begin
		state_next = state_reg;
		n_next     = n_reg;
		bin_next   = bin_reg;
		bcd_next   = bcd_reg;
		case (state_reg)
			ST_IDLE:
				if (start)
				begin
					bcd_next   = cmd.operand;
					bin_next   = '0;
					n_next     = CONV_ITER;
					state_next = digit_bad ? ST_DONE : ST_OP; // bad digit skips the shifts
				end
			ST_OP:
			begin
				bin_next = {bcd_reg[0][0], bin_reg[BIN_W-1:1]};
				for (int i = 0; i < 3; i++)
					bcd_next[i] = (bcd_tmp[i] > 4'd7) ? bcd_tmp[i] - 4'd3 : bcd_tmp[i];
				bcd_next[3] = bcd_tmp[3];
				n_next      = n_reg - 1'b1;
				if (n_reg == ITER_W'(1))
					state_next = ST_DONE;
			end
			ST_DONE:
				if (grant)
					state_next = ST_IDLE; // result taken by the arbiter
			default: state_next = ST_IDLE;
		endcase
	end

	assign ready = (state_reg == ST_IDLE);
	assign req   = (state_reg == ST_DONE);

	always_comb
	begin
		res.op    = op_reg;
		res.tag   = tag_reg;
		res.value = {{(OPERAND_W-BIN_W){1'b0}}, bin_reg}; // zero when flagged
		res.err   = err_reg;
	end

endmodule

// File: source/bin2bcd.sv
`timescale 1ns/100ps

module bin2bcd
	(
		input  logic                iCLK,
		input  logic                iRESET,
		input  logic                start,
		input  conv_pkg::conv_cmd_t cmd,
		input  logic                grant,
		output logic                ready,
		output logic                req,
		output conv_pkg::conv_res_t res
	);

	import conv_pkg::*;

	eng_state_e        state_reg, state_next;
	logic [ITER_W-1:0] n_reg, n_next;
	logic [BIN_W-1:0]  bin_reg, bin_next;
	logic [3:0][3:0]   bcd_reg, bcd_next, bcd_adj;
	conv_op_e          op_reg;
	logic [TAG_W-1:0]  tag_reg;
	logic              err_reg;
	logic              range_bad;

	always_ff @(posedge iCLK, posedge iRESET)
		if (iRESET)
		begin
			state_reg <= ST_IDLE;
			n_reg     <= '0;
		end
		else
		begin
			state_reg <= state_next;
			n_reg     <= n_next;
		end

	always_ff @(posedge iCLK)
	begin
		bin_reg <= bin_next;
		bcd_reg <= bcd_next;
		if (start && state_reg == ST_IDLE)
		begin
			op_reg  <= cmd.op;
			tag_reg <= cmd.tag;
			err_reg <= range_bad;
		end
	end

	assign range_bad = (cmd.operand > BCD_MAX); // also catches the upper operand bits

	// add 3 to every digit at or above 5 before the shift
	always_comb
		for (int i = 0; i < 4; i++)
			bcd_adj[i] = (bcd_reg[i] >= 4'd5) ? bcd_reg[i] + 4'd3 : bcd_reg[i];

	always_comb
	begin
		state_next = state_reg;
		n_next     = n_reg;
		bin_next   = bin_reg;
		bcd_next   = bcd_reg;
		case (state_reg)
			ST_IDLE:
				if (start)
				begin
					bcd_next   = '0;
					bin_next   = range_bad ? '0 : cmd.operand[BIN_W-1:0];
					n_next     = CONV_ITER;
					state_next = range_bad ? ST_DONE : ST_OP;
				end
			ST_OP:
			begin
				bcd_next = {bcd_adj[3][2:0], bcd_adj[2], bcd_adj[1], bcd_adj[0],
					bin_reg[BIN_W-1]};                   // msb of binary enters digit 0
				bin_next = {bin_reg[BIN_W-2:0], 1'b0};
				n_next   = n_reg - 1'b1;
				if (n_reg == ITER_W'(1))
					state_next = ST_DONE;
			end
			ST_DONE:
				if (grant)
					state_next = ST_IDLE;
			default: state_next = ST_IDLE;
		endcase
	end

	assign ready = (state_reg == ST_IDLE);
	assign req   = (state_reg == ST_DONE);

	always_comb
	begin
		res.op    = op_reg;
		res.tag   = tag_reg;
		res.value = bcd_reg;
		res.err   = err_reg;
	end

endmodule

// File: source/conv_dispatch.sv
`timescale 1ns/100ps

module conv_dispatch
	(
		input  logic                iCLK,
		input  logic                iRESET,
		input  logic                cmd_valid,
		input  conv_pkg::conv_cmd_t cmd,
		input  logic                bcd_ready,
		input  logic                bin_ready,
		output logic                bcd_start,
		output logic                bin_start,
		output conv_pkg::conv_cmd_t eng_cmd,
		output logic                cmd_reject
	);

	import conv_pkg::*;

	logic bcd_free, bin_free;
	logic bcd_hit, bin_hit;

	// an engine is still idle while its start is out, so count it busy
	assign bcd_free = bcd_ready && !bcd_start;
	assign bin_free = bin_ready && !bin_start;

	always_comb
	begin
		bcd_hit = 1'b0;
		bin_hit = 1'b0;
		case (cmd.op)
			OP_BCD2BIN: bcd_hit = bcd_free;
			OP_BIN2BCD: bin_hit = bin_free;
			default:                     // OP_NONE and OP_RSVD
			begin
				bcd_hit = 1'b0;
				bin_hit = 1'b0;
			end
		endcase
	end

	always_ff @(posedge iCLK, posedge iRESET)
		if (iRESET)
		begin
			bcd_start  <= 1'b0;
			bin_start  <= 1'b0;
			cmd_reject <= 1'b0;
		end
		else
		begin
			bcd_start  <= cmd_valid && bcd_hit;
			bin_start  <= cmd_valid && bin_hit;
			cmd_reject <= cmd_valid && !(bcd_hit || bin_hit);
		end

	always_ff @(posedge iCLK)
		if (cmd_valid)
			eng_cmd <= cmd;

endmodule

// File: source/result_arbiter.sv
`timescale 1ns/100ps

module result_arbiter
	(
		input  logic                iCLK,
		input  logic                iRESET,
		input  logic                bcd_req,
		input  conv_pkg::conv_res_t bcd_res,
		input  logic                bin_req,
		input  conv_pkg::conv_res_t bin_res,
		output logic                bcd_grant,
		output logic                bin_grant,
		output logic                res_valid,
		output conv_pkg::conv_res_t res
	);

	logic prio_bin; // set when bin2bcd wins a tie

	// ****************************************
	// combinational round-robin grant

	assign bcd_grant = bcd_req && (!bin_req || !prio_bin);
	assign bin_grant = bin_req && (!bcd_req || prio_bin);

	// ****************************************
	// pointer and result bus

	always_ff @(posedge iCLK, posedge iRESET)
		if (iRESET)
		begin
			prio_bin  <= 1'b0;
			res_valid <= 1'b0;
		end
		else
		begin
			if (bcd_grant)
				prio_bin <= 1'b1;        // winner drops to low priority
			else if (bin_grant)
				prio_bin <= 1'b0;
			res_valid <= bcd_grant || bin_grant;
		end

	always_ff @(posedge iCLK)
		if (bcd_grant)
			res <= bcd_res;
		else if (bin_grant)
			res <= bin_res;

endmodule

// File: source/conv_top.sv
`timescale 1ns/100ps

module conv_top
	(
		input  logic                iCLK,
		input  logic                iRESET,
		input  logic                cmd_valid,
		input  conv_pkg::conv_cmd_t cmd,
		output logic                cmd_reject,
		output logic                bcd_ready,
		output logic                bin_ready,
		output logic                res_valid,
		output conv_pkg::conv_res_t res
	);

	import conv_pkg::*;

	conv_cmd_t eng_cmd;
	conv_res_t bcd_res, bin_res;
	logic      bcd_start, bin_start;
	logic      bcd_req, bin_req;
	logic      bcd_grant, bin_grant;

	conv_dispatch i_dispatch
		(
			.iCLK(iCLK), .iRESET(iRESET),
			.cmd_valid(cmd_valid), .cmd(cmd),
			.bcd_ready(bcd_ready), .bin_ready(bin_ready),
			.bcd_start(bcd_start), .bin_start(bin_start),
			.eng_cmd(eng_cmd), .cmd_reject(cmd_reject)
		);

	bcd2bin i_bcd2bin
		(
			.iCLK(iCLK), .iRESET(iRESET),
			.start(bcd_start), .cmd(eng_cmd), .grant(bcd_grant),
			.ready(bcd_ready), .req(bcd_req), .res(bcd_res)
		);

	bin2bcd i_bin2bcd
		(
			.iCLK(iCLK), .iRESET(iRESET),
			.start(bin_start), .cmd(eng_cmd), .grant(bin_grant),
			.ready(bin_ready), .req(bin_req), .res(bin_res)
		);

	result_arbiter i_arbiter
		(
			.iCLK(iCLK), .iRESET(iRESET),
			.bcd_req(bcd_req), .bcd_res(bcd_res),
			.bin_req(bin_req), .bin_res(bin_res),
			.bcd_grant(bcd_grant), .bin_grant(bin_grant),
			.res_valid(res_valid), .res(res)
		);

endmodule

// File: bench/clock_gen.sv
`timescale 1ns/100ps

module clock_gen
	(
		output logic iCLK,
		output logic iRESET
	);

	initial
	begin
		iCLK   = 1'b0;
		iRESET <= 1'b1;
		repeat (5) @(posedge iCLK);
		iRESET <= 1'b0;
	end

	always #2 iCLK = ~iCLK; // 4 ns period

endmodule

// File: bench/conv_props.sv
`timescale 1ns/100ps

module conv_props
	(
		input logic                iCLK,
		input logic                iRESET,
		input logic                cmd_valid,
		input logic                cmd_reject,
		input logic                res_valid,
		input conv_pkg::conv_res_t res
	);

	import conv_pkg::*;

	logic             valid_d, res_valid_d;
	logic [TAG_W-1:0] tag_d;
	logic [3:0]       open_cnt; // accepted commands still waiting for a result
	logic [7:0]       wait_cnt;

	always_ff @(posedge iCLK, posedge iRESET)
		if (iRESET)
		begin
			valid_d     <= 1'b0;
			res_valid_d <= 1'b0;
			tag_d       <= '0;
			open_cnt    <= '0;
			wait_cnt    <= '0;
		end
		else
		begin
			valid_d     <= cmd_valid;
			res_valid_d <= res_valid;
			tag_d       <= res.tag;
			open_cnt    <= open_cnt + 4'(valid_d && !cmd_reject) - 4'(res_valid);
			wait_cnt    <= (res_valid || open_cnt == '0) ? '0 : wait_cnt + 8'd1;
		end

	quiet_in_reset: assert property (@(posedge iCLK) iRESET |-> !res_valid && !cmd_reject)
		else $error("strobe raised during reset");

	reject_single: assert property (@(posedge iCLK) disable iff (iRESET) cmd_reject |-> valid_d)
		else $error("reject without a command strobe the cycle before");

	result_single: assert property (@(posedge iCLK) disable iff (iRESET)
		res_valid && res_valid_d |-> res.tag != tag_d)
		else $error("result strobe held for a second cycle");

	answered: assert property (@(posedge iCLK) disable iff (iRESET)
		wait_cnt < 8'd32 && (!res_valid || open_cnt != '0))
		else $error("accepted command not answered in time");

endmodule

bind conv_top conv_props i_props
	(
		.iCLK(iCLK), .iRESET(iRESET), .cmd_valid(cmd_valid),
		.cmd_reject(cmd_reject), .res_valid(res_valid), .res(res)
	);

// File: bench/conv_tb.sv
`timescale 1ns/100ps

module conv_tb;

	import conv_pkg::*;

	localparam int               WAIT_LIMIT = 100;  // cycles allowed for one wait
	localparam logic [TAG_W-1:0] REJ_TAG    = 4'hf; // only used by commands that must bounce

	logic      iCLK, iRESET;
	logic      cmd_valid;
	conv_cmd_t cmd;
	logic      cmd_reject, bcd_ready, bin_ready, res_valid;
	conv_res_t res;

	conv_res_t        exp_q [16]; // expected result per tag
	bit               pending [16];
	int               num_accepted, num_results;
	logic [31:0]      lfsr;
	logic [TAG_W-1:0] next_tag;

	clock_gen i_clock (.iCLK(iCLK), .iRESET(iRESET));

	conv_top i_dut (.*);

	// ****************************************
	// stimulus helpers and reference model

	task automatic end_in_failure;
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("[ERROR] time %0d ns %s: got %0h, expected %0h", $time, name, got, exp);
			end_in_failure();
		end
	endtask

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			bits = {bits[30:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
		end
		return bits;
	endfunction

	function automatic logic [15:0] rand_bcd();
		logic [15:0] digits;
		for (int i = 0; i < 4; i++)
			digits[4*i +: 4] = 4'(rand_bits(4) % 10);
		return digits;
	endfunction

	function automatic logic [15:0] rand_bad_bcd();
		logic [15:0] digits;
		logic [1:0]  pos;
		digits = rand_bcd();
		pos    = 2'(rand_bits(2));
		digits[4*pos +: 4] = 4'(10 + rand_bits(3) % 6); // one digit from 10 to 15
		return digits;
	endfunction

	function automatic conv_res_t ref_convert(input conv_cmd_t c);
		conv_res_t r;
		int        d [4];
		int        v;
		r.op    = c.op;
		r.tag   = c.tag;
		r.value = '0;
		r.err   = 1'b0;
		for (int i = 0; i < 4; i++)
			d[i] = int'(c.operand[4*i +: 4]);
		v = int'(c.operand);
		if (c.op == OP_BCD2BIN)
		begin
			if (d[0] > 9 || d[1] > 9 || d[2] > 9 || d[3] > 9)
				r.err = 1'b1;
			else
				r.value = 16'(d[3] * 1000 + d[2] * 100 + d[1] * 10 + d[0]);
		end
		else if (v > 9999)
			r.err = 1'b1;
		else
			r.value = {4'(v / 1000), 4'((v / 100) % 10), 4'((v / 10) % 10), 4'(v % 10)};
		return r;
	endfunction

	task automatic wait_ready(input conv_op_e op);
		int n;
		n = 0;
		@(negedge iCLK);
		while (!(op == OP_BCD2BIN ? bcd_ready : bin_ready))
		begin
			if (n == WAIT_LIMIT)
			begin
				$display("timeout waiting for engine %s to become ready", op.name());
				end_in_failure();
			end
			n++;
			@(negedge iCLK);
		end
	endtask

	task automatic wait_idle;
		int n;
		n = 0;
		@(negedge iCLK);
		while (num_results != num_accepted || !bcd_ready || !bin_ready)
		begin
			if (n == WAIT_LIMIT)
			begin
				$display("timeout waiting for all results to come back");
				end_in_failure();
			end
			n++;
			@(negedge iCLK);
		end
	endtask

	task automatic send_cmd(input conv_op_e op, input logic [TAG_W-1:0] tag,
		input logic [15:0] operand, input bit expect_reject);
		conv_cmd_t c;
		c.op      = op;
		c.tag     = tag;
		c.operand = operand;
		if (!expect_reject)
		begin
			if (pending[tag])
			begin
				$display("tag %0d reused while its result is still outstanding", tag);
				end_in_failure();
			end
			exp_q[tag]   = ref_convert(c);
			pending[tag] = 1'b1;
			num_accepted++;
		end
		@(posedge iCLK);
		cmd_valid <= 1'b1;
		cmd       <= c;
		@(posedge iCLK);
		cmd_valid <= 1'b0;
		@(negedge iCLK);
		check("cmd_reject", 32'(cmd_reject), 32'(expect_reject));
	endtask

	task automatic issue(input conv_op_e op, input logic [15:0] operand);
		wait_ready(op);
		send_cmd(op, next_tag, operand, 1'b0);
		next_tag = (next_tag == 4'd14) ? 4'd0 : next_tag + 4'd1;
	endtask

	// ****************************************
	// result comparison

	always @(negedge iCLK)
		if (!iRESET && res_valid)
		begin
			if (!pending[res.tag])
			begin
				$display("result with tag %0d arrived without an open command", res.tag);
				end_in_failure();
			end
			check("res.op", 32'(res.op), 32'(exp_q[res.tag].op));
			check("res.value", 32'(res.value), 32'(exp_q[res.tag].value));
			check("res.err", 32'(res.err), 32'(exp_q[res.tag].err));
			pending[res.tag] = 1'b0;
			num_results++;
		end

	// ****************************************
	// test sequence

	initial
	begin
		int n;
		cmd_valid    <= 1'b0;
		cmd          <= '0;
		lfsr         = 32'ha2a9;
		next_tag     = '0;
		num_accepted = 0;
		num_results  = 0;
		n            = 0;
		@(negedge iCLK);
		while (iRESET)
		begin
			if (n == WAIT_LIMIT)
			begin
				$display("timeout waiting for reset to be released");
				end_in_failure();
			end
			n++;
			@(negedge iCLK);
		end
		check("res_valid", 32'(res_valid), 32'd0);
		check("cmd_reject", 32'(cmd_reject), 32'd0);
		check("bcd_ready", 32'(bcd_ready), 32'd1);
		check("bin_ready", 32'(bin_ready), 32'd1);

		issue(OP_BCD2BIN, 16'h0000); // corner values and error cases
		issue(OP_BCD2BIN, 16'h9999);
		issue(OP_BIN2BCD, 16'd0);
		issue(OP_BIN2BCD, 16'd9999);
		issue(OP_BIN2BCD, 16'd10000);
		issue(OP_BIN2BCD, 16'h4000);
		issue(OP_BIN2BCD, 16'hffff);
		issue(OP_BCD2BIN, 16'h00a0);
		issue(OP_BCD2BIN, 16'hf123);
		issue(OP_BCD2BIN, 16'h999c);
		wait_idle();

		for (int i = 0; i < 40; i++)
		begin
			issue(OP_BCD2BIN, (i % 4 == 3) ? rand_bad_bcd() : rand_bcd());
			if (i % 4 == 2)
				issue(OP_BIN2BCD, 16'(10000 + rand_bits(15) % 55536));
			else
				issue(OP_BIN2BCD, 16'(rand_bits(14) % 10000));
		end
		wait_idle();

		issue(OP_BCD2BIN, 16'h1234); // second command hits a busy engine
		send_cmd(OP_BCD2BIN, REJ_TAG, 16'h4321, 1'b1);
		issue(OP_BIN2BCD, 16'd1234);
		send_cmd(OP_BIN2BCD, REJ_TAG, 16'd4321, 1'b1);
		wait_idle();
		send_cmd(OP_NONE, REJ_TAG, 16'd1, 1'b1);
		send_cmd(OP_RSVD, REJ_TAG, 16'd1, 1'b1);

		// sweep the offset so both engines request the bus in the same cycle
		for (int d = 0; d < 16; d++)
		begin
			issue(OP_BIN2BCD, 16'(rand_bits(14) % 10000));
			repeat (d) @(posedge iCLK);
			issue(OP_BCD2BIN, 16'ha000);
			wait_idle();
			issue(OP_BCD2BIN, rand_bcd());
			repeat (d) @(posedge iCLK);
			issue(OP_BIN2BCD, 16'hffff);
			wait_idle();
		end

		wait_idle();
		if (num_results == num_accepted && num_accepted > 0)
		begin
			$display("all tests passed");
			$finish;
		end
		else
		begin
			$display("%0d commands accepted, %0d results seen", num_accepted, num_results);
			end_in_failure();
		end
	end

endmodule

// File: files.f
source/conv_pkg.sv
source/bcd2bin.sv
source/bin2bcd.sv
source/conv_dispatch.sv
source/result_arbiter.sv
source/conv_top.sv
bench/clock_gen.sv
bench/conv_props.sv
bench/conv_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "make help   list the targets"
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build output"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module conv_tb -Mdir obj_dir -f files.f
	./obj_dir/Vconv_tb

clean:
	rm -rf obj_dir
